// File: source/feeder_defs.svh
`ifndef FEEDER_DEFS_SVH
`define FEEDER_DEFS_SVH

// datapath widths
`define FEEDER_XLEN        32
`define FEEDER_WORD_W      16
`define FEEDER_LINE_W      512
`define FEEDER_LINE_WORDS  32
`define FEEDER_IDX_W       15
`define FEEDER_OP_W        8

// host register map, absolute addresses
`define REG_CMD_ADDR       32'hC400_0000
`define REG_BUSY_ADDR      32'hC400_0020
`define REG_RD_ADDR        32'hC400_2024
`define REG_RD_LEN         32'hC400_2028
`define REG_RD_TRIGGER     32'hC400_202C
`define REG_SRAM_OFFSET    32'hC400_2034
`define REG_DATA_TYPE      32'hC400_2038
`define REG_RD_OFFSET      32'hC400_2070
`define REG_RD_ROUNDS      32'hC400_2074

// accelerator load opcodes
`define OP_LOAD_INPUT      8'd9
`define OP_LOAD_WEIGHT     8'd10

`endif

// File: source/feeder_pkg.sv
`default_nettype none

`include "feeder_defs.svh"

package feeder_pkg;

    // host strobe bus, write only plus busy read
    typedef struct packed {
        logic                    strobe;
        logic [`FEEDER_XLEN-1:0] addr;
        logic [`FEEDER_XLEN-1:0] wdata;
    } bus_req_t;

    typedef enum logic [0:0] {
        DT_INPUT  = 1'b0,
        DT_WEIGHT = 1'b1
    } data_type_t;

    // read transfer configuration
    typedef struct packed {
        logic [`FEEDER_XLEN-1:0]  base;
        logic [`FEEDER_IDX_W-1:0] len;     // words per round
        logic [`FEEDER_XLEN-1:0]  offset;  // byte step between rounds
        logic [15:0]              rounds;
        data_type_t               dtype;
    } rd_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic [`FEEDER_XLEN-1:0] addr;
        logic                    rw;       // 0 read, 1 write
    } dram_req_t;

    typedef struct packed {
        logic                      valid;
        logic [`FEEDER_WORD_W-1:0] data;
    } word_beat_t;

    typedef struct packed {
        logic                      valid;
        logic [`FEEDER_OP_W-1:0]   opcode;
        logic [`FEEDER_WORD_W-1:0] param1;
        logic [`FEEDER_IDX_W-1:0]  param2;
    } tpu_cmd_t;

endpackage

`default_nettype wire

// File: source/feeder_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "feeder_defs.svh"

module feeder_regs import feeder_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  bus_req_t                bus_i,
    input  logic                    req_busy_i,
    input  logic                    unpack_busy_i,
    output logic                    ready_o,
    output logic [`FEEDER_XLEN-1:0] data_o,
    output rd_cfg_t                 cfg_o,
    output logic                    start_o,
    output logic                    idx_clear_o
);

    logic hit_busy;
    logic hit_rd_addr;
    logic hit_rd_len;
    logic hit_trigger;
    logic hit_sram_off;
    logic hit_dtype;
    logic hit_rd_off;
    logic hit_rounds;

    // ##############################
    // address decode
    // ##############################
    assign hit_busy     = bus_i.strobe && (bus_i.addr == `REG_BUSY_ADDR);
    assign hit_rd_addr  = bus_i.strobe && (bus_i.addr == `REG_RD_ADDR);
    assign hit_rd_len   = bus_i.strobe && (bus_i.addr == `REG_RD_LEN);
    assign hit_trigger  = bus_i.strobe && (bus_i.addr == `REG_RD_TRIGGER);
    assign hit_sram_off = bus_i.strobe && (bus_i.addr == `REG_SRAM_OFFSET);
    assign hit_dtype    = bus_i.strobe && (bus_i.addr == `REG_DATA_TYPE);
    assign hit_rd_off   = bus_i.strobe && (bus_i.addr == `REG_RD_OFFSET);
    assign hit_rounds   = bus_i.strobe && (bus_i.addr == `REG_RD_ROUNDS);

    // configuration fields
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_o <= '{base: '0, len: '0, offset: '0, rounds: 16'd1, dtype: DT_INPUT};
        end else begin
            if (hit_rd_addr) begin
                cfg_o.base <= bus_i.wdata;
            end
            if (hit_rd_len) begin
                cfg_o.len <= bus_i.wdata[`FEEDER_IDX_W-1:0];
            end
            if (hit_rd_off) begin
                cfg_o.offset <= bus_i.wdata;
            end
            if (hit_rounds) begin
                cfg_o.rounds <= bus_i.wdata[15:0];
            end
            if (hit_dtype) begin
                cfg_o.dtype <= data_type_t'(bus_i.wdata[0]);
            end
        end
    end

    // ##############################
    // bus response and pulses
    // ##############################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_o     <= 1'b0;
            start_o     <= 1'b0;
            idx_clear_o <= 1'b0;
            data_o      <= '0;
        end else begin
            ready_o     <= bus_i.strobe;
            start_o     <= hit_trigger;
            idx_clear_o <= hit_sram_off;
            // busy if either side is still working
            if (hit_busy) begin
                data_o <= {{(`FEEDER_XLEN-1){1'b0}}, req_busy_i | unpack_busy_i};
            end
        end
    end

endmodule

`default_nettype wire

// File: source/read_req_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "feeder_defs.svh"

module read_req_gen import feeder_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  rd_cfg_t   cfg_i,
    input  logic      start_i,
    input  logic      fifo_addr_full_i,
    input  logic      dram_rw_full_i,
    output dram_req_t req_o,
    output logic      busy_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_FIFO,
        S_SEND,
        S_NEXT_ROUND
    } req_state_t;

    req_state_t               state;
    logic [`FEEDER_XLEN-1:0]  cur_addr;
    logic [`FEEDER_XLEN-1:0]  round_base;
    logic [`FEEDER_IDX_W-1:0] word_cnt;
    logic [15:0]              round_cnt;

    logic [5:0]               line_words;
    logic [`FEEDER_IDX_W:0]   cnt_next;
    logic                     round_done;
    logic                     last_round;

    // words left until the next 64-byte boundary
    assign line_words = 6'd32 - {1'b0, cur_addr[5:1]};
    assign cnt_next   = {1'b0, word_cnt} + (`FEEDER_IDX_W+1)'(line_words);
    assign round_done = cnt_next >= {1'b0, cfg_i.len};
    assign last_round = ({1'b0, round_cnt} + 17'd1) >= {1'b0, cfg_i.rounds};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= S_IDLE;
            cur_addr   <= '0;
            round_base <= '0;
            word_cnt   <= '0;
            round_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        cur_addr   <= cfg_i.base;
                        round_base <= cfg_i.base;
                        word_cnt   <= '0;
                        round_cnt  <= '0;
                        state      <= S_WAIT_FIFO;
                    end
                end
                S_WAIT_FIFO: begin
                    // hold while either queue is full
                    if (!fifo_addr_full_i && !dram_rw_full_i) begin
                        state <= S_SEND;
                    end
                end
                S_SEND: begin
                    cur_addr <= {cur_addr[`FEEDER_XLEN-1:6] + 1'b1, 6'b0};
                    word_cnt <= cnt_next[`FEEDER_IDX_W-1:0];
                    state    <= round_done ? S_NEXT_ROUND : S_WAIT_FIFO;
                end
                S_NEXT_ROUND: begin
                    cur_addr   <= round_base + cfg_i.offset;
                    round_base <= round_base + cfg_i.offset;
                    word_cnt   <= '0;
                    round_cnt  <= round_cnt + 16'd1;
                    state      <= last_round ? S_IDLE : S_WAIT_FIFO;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign req_o  = '{valid: (state == S_SEND), addr: cur_addr, rw: 1'b0};
    assign busy_o = (state != S_IDLE);

endmodule

`default_nettype wire

// File: source/line_unpack.sv
`timescale 1ns/10ps
`default_nettype none

`include "feeder_defs.svh"

module line_unpack import feeder_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  rd_cfg_t                     cfg_i,
    input  logic                        start_i,
    input  logic                        fifo_data_empty_i,
    input  logic [`FEEDER_LINE_W/2-1:0] dram_read_data_h_i,
    input  logic [`FEEDER_LINE_W/2-1:0] dram_read_data_l_i,
    output logic                        fifo_data_rd_en_o,
    output word_beat_t                  beat_o,
    output logic                        busy_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_DATA,
        S_STREAM,
        S_RELEASE,
        S_NEXT_ROUND
    } unpack_state_t;

    unpack_state_t            state;
    logic [`FEEDER_XLEN-1:0]  got_addr;
    logic [`FEEDER_XLEN-1:0]  round_base;
    logic [`FEEDER_IDX_W-1:0] word_cnt;
    logic [15:0]              round_cnt;

    // word k sits at bits 16k+15:16k of {high, low}
    logic [`FEEDER_LINE_WORDS-1:0][`FEEDER_WORD_W-1:0] line_q;

    logic [4:0] word_sel;
    logic       line_end;
    logic       len_reached;
    logic       last_round;

    assign word_sel    = got_addr[5:1];
    assign line_end    = (word_sel == 5'd31);
    assign len_reached = ({1'b0, word_cnt} + 1'b1) >= {1'b0, cfg_i.len};
    assign last_round  = ({1'b0, round_cnt} + 17'd1) >= {1'b0, cfg_i.rounds};

    // head of the return FIFO
    always_ff @(posedge clk_i) begin
        if (!fifo_data_empty_i) begin
            line_q <= {dram_read_data_h_i, dram_read_data_l_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= S_IDLE;
            got_addr   <= '0;
            round_base <= '0;
            word_cnt   <= '0;
            round_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        got_addr   <= cfg_i.base;
                        round_base <= cfg_i.base;
                        word_cnt   <= '0;
                        round_cnt  <= '0;
                        state      <= S_WAIT_DATA;
                    end
                end
                S_WAIT_DATA: begin
                    if (!fifo_data_empty_i) begin
                        state <= S_STREAM;
                    end
                end
                S_STREAM: begin
                    got_addr <= got_addr + 2;
                    word_cnt <= word_cnt + 1'b1;
                    if (line_end || len_reached) begin
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    state <= (word_cnt >= cfg_i.len) ? S_NEXT_ROUND : S_WAIT_DATA;
                end
                S_NEXT_ROUND: begin
                    // same restart rule as the request side
                    got_addr   <= round_base + cfg_i.offset;
                    round_base <= round_base + cfg_i.offset;
                    word_cnt   <= '0;
                    round_cnt  <= round_cnt + 16'd1;
                    state      <= last_round ? S_IDLE : S_WAIT_DATA;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign beat_o            = '{valid: (state == S_STREAM), data: line_q[word_sel]};
    assign fifo_data_rd_en_o = (state == S_RELEASE);
    assign busy_o            = (state != S_IDLE);

endmodule

`default_nettype wire

// File: source/cmd_emit.sv
`timescale 1ns/10ps
`default_nettype none

`include "feeder_defs.svh"

module cmd_emit import feeder_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  rd_cfg_t    cfg_i,
    input  logic       idx_clear_i,
    input  word_beat_t beat_i,
    output tpu_cmd_t   cmd_o
);

    // buffer index, kept across transfers
    logic [`FEEDER_IDX_W-1:0] buf_idx;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            buf_idx <= '0;
        end else if (idx_clear_i) begin
            buf_idx <= '0;
        end else if (beat_i.valid) begin
            buf_idx <= buf_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_o.valid <= 1'b0;
        end else begin
            cmd_o.valid <= beat_i.valid;
        end
    end

    // payload follows the beat
    always_ff @(posedge clk_i) begin
        if (beat_i.valid) begin
            cmd_o.opcode <= (cfg_i.dtype == DT_WEIGHT) ? `OP_LOAD_WEIGHT : `OP_LOAD_INPUT;
            cmd_o.param1 <= beat_i.data;
            cmd_o.param2 <= buf_idx;
        end
    end

endmodule

`default_nettype wire

// File: source/data_feeder_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "feeder_defs.svh"

module data_feeder_top import feeder_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  bus_req_t                    bus_i,
    input  logic                        fifo_addr_full_i,
    input  logic                        dram_rw_full_i,
    input  logic                        fifo_data_empty_i,
    input  logic [`FEEDER_LINE_W/2-1:0] dram_read_data_h_i,
    input  logic [`FEEDER_LINE_W/2-1:0] dram_read_data_l_i,
    output logic                        ready_o,
    output logic [`FEEDER_XLEN-1:0]     data_o,
    output dram_req_t                   dram_req_o,
    output logic                        fifo_data_rd_en_o,
    output tpu_cmd_t                    cmd_o
);

    rd_cfg_t    cfg;
    logic       start;
    logic       idx_clear;
    logic       req_busy;
    logic       unpack_busy;
    word_beat_t beat;

    // ##############################
    // host side
    // ##############################
    feeder_regs u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_i        (bus_i),
        .req_busy_i   (req_busy),
        .unpack_busy_i(unpack_busy),
        .ready_o      (ready_o),
        .data_o       (data_o),
        .cfg_o        (cfg),
        .start_o      (start),
        .idx_clear_o  (idx_clear)
    );

    // ##############################
    // DRAM read path
    // ##############################
    read_req_gen u_req (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cfg_i           (cfg),
        .start_i         (start),
        .fifo_addr_full_i(fifo_addr_full_i),
        .dram_rw_full_i  (dram_rw_full_i),
        .req_o           (dram_req_o),
        .busy_o          (req_busy)
    );

    line_unpack u_unpack (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .cfg_i             (cfg),
        .start_i           (start),
        .fifo_data_empty_i (fifo_data_empty_i),
        .dram_read_data_h_i(dram_read_data_h_i),
        .dram_read_data_l_i(dram_read_data_l_i),
        .fifo_data_rd_en_o (fifo_data_rd_en_o),
        .beat_o            (beat),
        .busy_o            (unpack_busy)
    );

    // accelerator command stage
    cmd_emit u_emit (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_i      (cfg),
        .idx_clear_i(idx_clear),
        .beat_i     (beat),
        .cmd_o      (cmd_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_data_feeder.sv
`timescale 1ns/10ps
`default_nettype none

`include "feeder_defs.svh"

module tb_data_feeder import feeder_pkg::*; ();

    logic                        clk;
    logic                        rst;
    bus_req_t                    bus;
    logic                        fifo_addr_full;
    logic                        dram_rw_full;
    logic                        fifo_data_empty;
    logic [`FEEDER_LINE_W/2-1:0] rd_data_h;
    logic [`FEEDER_LINE_W/2-1:0] rd_data_l;
    logic                        ready;
    logic [`FEEDER_XLEN-1:0]     rd_word;
    dram_req_t                   dram_req;
    logic                        rd_en;
    tpu_cmd_t                    cmd;

    // DRAM model queues and monitor records
    logic [`FEEDER_LINE_W-1:0]   pending[$];
    logic [`FEEDER_LINE_W-1:0]   lines_log[$];
    dram_req_t                   got_reqs[$];
    tpu_cmd_t                    got_cmds[$];
    logic [31:0]                 lcg_state;
    logic [`FEEDER_IDX_W-1:0]    exp_idx;

    data_feeder_top UUT (
        .clk_i             (clk),
        .rst_i             (rst),
        .bus_i             (bus),
        .fifo_addr_full_i  (fifo_addr_full),
        .dram_rw_full_i    (dram_rw_full),
        .fifo_data_empty_i (fifo_data_empty),
        .dram_read_data_h_i(rd_data_h),
        .dram_read_data_l_i(rd_data_l),
        .ready_o           (ready),
        .data_o            (rd_word),
        .dram_req_o        (dram_req),
        .fifo_data_rd_en_o (rd_en),
        .cmd_o             (cmd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`FEEDER_LINE_W-1:0] fill_line();
        logic [`FEEDER_LINE_W-1:0] line;
        for (int i = 0; i < 16; i++) begin
            line[32*i +: 32] = lcg_next();
        end
        return line;
    endfunction

    // ##############################
    // DRAM model and output monitor
    // ##############################
    always @(posedge clk) begin
        #1;
        if (dram_req.valid) begin
            got_reqs.push_back(dram_req);
            pending.push_back(fill_line());
            lines_log.push_back(pending[$]);
        end
        if (rd_en) begin
            if (pending.size() == 0) begin
                fail_now("FIFO read enable while the return FIFO is empty");
            end
            void'(pending.pop_front());
        end
        if (cmd.valid) begin
            got_cmds.push_back(cmd);
        end
        // head of the return queue
        fifo_data_empty = (pending.size() == 0);
        if (pending.size() == 0) begin
            {rd_data_h, rd_data_l} = '0;
        end else begin
            {rd_data_h, rd_data_l} = pending[0];
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_cmd(input string name, input tpu_cmd_t got, input tpu_cmd_t exp);
        if (got !== exp) begin
            fail_now($sformatf("error at %0d ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_req(input string name, input dram_req_t got, input dram_req_t exp);
        if (got !== exp) begin
            fail_now($sformatf("error at %0d ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("error at %0d ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // ##############################
    // host bus access
    // ##############################
    task automatic bus_write(input logic [31:0] reg_addr, input logic [31:0] value);
        bus = '{strobe: 1'b1, addr: reg_addr, wdata: value};
        @(posedge clk);
        #1;
        bus.strobe = 1'b0;
        compare_word("ready_o", {31'd0, ready}, 32'd1);
    endtask

    task automatic bus_read(input logic [31:0] reg_addr, output logic [31:0] value);
        bus = '{strobe: 1'b1, addr: reg_addr, wdata: 32'd0};
        @(posedge clk);
        #1;
        bus.strobe = 1'b0;
        compare_word("ready_o", {31'd0, ready}, 32'd1);
        value = rd_word;
    endtask

    task automatic wait_reqs(input int n);
        int t;
        t = 0;
        while (got_reqs.size() < n) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 1000) begin
                fail_now("timeout while waiting for DRAM read requests");
            end
        end
    endtask

    task automatic wait_cmds(input int n);
        int t;
        t = 0;
        while (got_cmds.size() < n) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 2000) begin
                fail_now("timeout while waiting for accelerator commands");
            end
        end
    endtask

    task automatic wait_idle();
        logic [31:0] busy;
        int          t;
        t = 0;
        busy = 32'd1;
        while (busy != 32'd0) begin
            bus_read(`REG_BUSY_ADDR, busy);
            t++;
            if (t > 500) begin
                fail_now("timeout while waiting for the feeder to go idle");
            end
        end
    endtask

    task automatic start_read(input logic [31:0] base, input int len, input logic [31:0] offset,
                              input int rounds, input data_type_t dtype);
        got_reqs.delete();
        got_cmds.delete();
        lines_log.delete();
        bus_write(`REG_RD_ADDR, base);
        bus_write(`REG_RD_LEN, len);
        bus_write(`REG_RD_OFFSET, offset);
        bus_write(`REG_RD_ROUNDS, rounds);
        bus_write(`REG_DATA_TYPE, {31'd0, dtype});
        bus_write(`REG_RD_TRIGGER, 32'd1);
    endtask

    // expected stream rebuilt from the stored lines
    // word k sits at bits 16k+15:16k
    task automatic finish_read(input logic [31:0] base, input int len, input logic [31:0] offset,
                               input int rounds, input logic [7:0] opcode);
        logic [31:0]               rbase;
        logic [31:0]               addr;
        logic [`FEEDER_LINE_W-1:0] line;
        dram_req_t                 exp_req;
        tpu_cmd_t                  exp_cmd;
        int                        li;
        int                        ci;
        int                        cnt;
        int                        w;
        wait_cmds(len * rounds);
        wait_idle();
        li = 0;
        ci = 0;
        rbase = base;
        for (int r = 0; r < rounds; r++) begin
            addr = rbase;
            cnt = 0;
            while (cnt < len) begin
                if (li >= got_reqs.size()) begin
                    fail_now("fewer DRAM read requests than expected");
                end
                exp_req = '{valid: 1'b1, addr: addr, rw: 1'b0};
                compare_req($sformatf("dram_req_o[%0d]", li), got_reqs[li], exp_req);
                line = lines_log[li];
                w = int'(addr[5:1]);
                while (w < 32 && cnt < len) begin
                    exp_cmd = '{valid: 1'b1, opcode: opcode, param1: line[16*w +: 16],
                                param2: exp_idx};
                    compare_cmd($sformatf("cmd_o[%0d]", ci), got_cmds[ci], exp_cmd);
                    exp_idx = exp_idx + 1'b1;
                    ci++;
                    cnt++;
                    w++;
                end
                addr = (addr & ~32'h3f) + 32'h40;
                li++;
            end
            rbase = rbase + offset;
        end
        compare_word("request count", got_reqs.size(), li);
        compare_word("command count", got_cmds.size(), ci);
        compare_word("return FIFO entries", pending.size(), 32'd0);
    endtask

    // ##############################
    // directed tests
    // ##############################
    task automatic test_reset_state();
        logic [31:0] busy;
        for (int i = 0; i < 8; i++) begin
            compare_word("ready_o", {31'd0, ready}, 32'd0);
            compare_word("dram_req_o.valid", {31'd0, dram_req.valid}, 32'd0);
            compare_word("fifo_data_rd_en_o", {31'd0, rd_en}, 32'd0);
            compare_word("cmd_o.valid", {31'd0, cmd.valid}, 32'd0);
            compare_word("data_o", rd_word, 32'd0);
            @(posedge clk);
            #1;
        end
        bus_read(`REG_BUSY_ADDR, busy);
        compare_word("busy", busy, 32'd0);
    endtask

    task automatic test_aligned_input();
        logic [31:0] busy;
        start_read(32'h1000, 48, 32'd0, 1, DT_INPUT);
        wait_reqs(1);
        bus_read(`REG_BUSY_ADDR, busy);
        compare_word("busy", busy, 32'd1);
        finish_read(32'h1000, 48, 32'd0, 1, `OP_LOAD_INPUT);
    endtask

    // two lines starting at word 8 of the first
    // index carries on from the last test
    task automatic test_unaligned_weight();
        start_read(32'h2010, 40, 32'd0, 1, DT_WEIGHT);
        finish_read(32'h2010, 40, 32'd0, 1, `OP_LOAD_WEIGHT);
        bus_write(`REG_SRAM_OFFSET, 32'd0);
        exp_idx = '0;
    endtask

    task automatic test_multi_round();
        start_read(32'h3000, 16, 32'h100, 3, DT_INPUT);
        finish_read(32'h3000, 16, 32'h100, 3, `OP_LOAD_INPUT);
    endtask

    task automatic test_back_pressure();
        bus_write(`REG_SRAM_OFFSET, 32'd0);
        exp_idx = '0;
        fifo_addr_full = 1'b1;
        start_read(32'h1000, 48, 32'd0, 1, DT_INPUT);
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            compare_word("request count", got_reqs.size(), 32'd0);
        end
        fifo_addr_full = 1'b0;
        wait_reqs(1);
        // hold the second request with the other full flag
        dram_rw_full = 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            compare_word("request count", got_reqs.size(), 32'd1);
        end
        dram_rw_full = 1'b0;
        finish_read(32'h1000, 48, 32'd0, 1, `OP_LOAD_INPUT);
    endtask

    initial begin
        rst = 1'b1;
        bus = '0;
        fifo_addr_full = 1'b0;
        dram_rw_full = 1'b0;
        fifo_data_empty = 1'b1;
        rd_data_h = '0;
        rd_data_l = '0;
        lcg_state = 32'hef47bbc6;
        exp_idx = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_aligned_input();
        test_unaligned_weight();
        test_multi_round();
        test_back_pressure();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/feeder_pkg.sv
source/feeder_regs.sv
source/read_req_gen.sv
source/line_unpack.sv
source/cmd_emit.sv
source/data_feeder_top.sv
tests/tb_data_feeder.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module tb_data_feeder -o tb_data_feeder \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_data_feeder > sim.log 2>&1
grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "test passed" sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"
